/* common/bubl_pkg.sv */
package bubl_pkg;

    ////////////////////////////////////////
    // Bus widths

    localparam int work_aw = 13;       // 8 KB shared work RAM

    typedef logic [15:0]        cpu_addr_t;
    typedef logic [7:0]         cpu_data_t;
    typedef logic [17:0]        rom_addr_t;    // Byte address into main program ROM
    typedef logic [2:0]         bank_t;
    typedef logic [work_aw-1:0] work_addr_t;
    typedef logic [14:0]        sub_rom_addr_t;

    ////////////////////////////////////////
    // Memory map

    localparam cpu_data_t unmapped_data = 8'hff;

    // Banked ROM window, page = bank + offset
    localparam logic [3:0] bank_offset = 4'd2;
    localparam bank_t      bank_xor    = 3'd4;

    // Compared against the top address bits of each window
    localparam logic [2:0] vram_page  = 3'b110;           // C000-DFFF, addr[15:13]
    localparam logic [2:0] work_page  = 3'b111;           // E000-..., addr[15:13]
    localparam logic [6:0] pal_page   = 7'b1111_100;      // F800-F9FF, addr[15:9]
    localparam logic [8:0] sound_page = 9'b1111_1010_0;   // FA00-FA7F, addr[15:7]
    localparam logic [9:0] nmi_page   = 10'b1111_1011_00; // FB00-FB3F, addr[15:6]
    localparam logic [9:0] misc_page  = 10'b1111_1011_01; // FB40-FB7F, addr[15:6]

    ////////////////////////////////////////
    // Register fields

    // Misc control byte
    localparam int ctrl_sub_rst_bit = 4;
    localparam int ctrl_black_bit   = 6;
    localparam int ctrl_flip_bit    = 7;

    // Sound window, low two address bits
    localparam logic [1:0] snd_latch_ofs = 2'd0;
    localparam logic [1:0] snd_reset_ofs = 2'd3;

endpackage

/* hw/bubl_main_decoder.sv */
`timescale 1ns/1ps

module bubl_main_decoder (
    input  bubl_pkg::cpu_addr_t main_addr,
    input  logic                main_mreq_n,
    input  logic                main_wr_n,
    input  bubl_pkg::bank_t     bank,
    output logic                main_rom_cs,
    output logic                vram_cs,
    output logic                pal_cs,
    output logic                work_cs,
    output logic                sound_cs,
    output logic                misc_cs,
    output logic                nmi_stb,
    output bubl_pkg::rom_addr_t main_rom_addr
);
    import bubl_pkg::*;

    logic       mreq;
    logic       wr;
    logic [3:0] rom_page;   // 16 KB page for the banked window

    assign mreq = !main_mreq_n;
    assign wr   = !main_wr_n;

    // Bubble Bobble map
    always_comb begin
        main_rom_cs = mreq && main_addr[15:14] != 2'b11;   // 0000-BFFF
        vram_cs     = mreq && main_addr[15:13] == vram_page;
        work_cs     = mreq && main_addr[15:13] == work_page
                           && main_addr[12:11] != 2'b11;  // Stops at F7FF
        pal_cs      = mreq && main_addr[15:9] == pal_page;
        sound_cs    = mreq && main_addr[15:7] == sound_page;
        // Write-only registers
        nmi_stb     = mreq && wr && main_addr[15:6] == nmi_page;
        misc_cs     = mreq && wr && main_addr[15:6] == misc_page;
    end

    ////////////////////////////////////////
    // Program ROM address

    assign rom_page = {1'b0, bank} + bank_offset;

    always_comb begin
        if (main_addr[15]) begin
            main_rom_addr = {rom_page, main_addr[13:0]};  // Banked window
        end else begin
            main_rom_addr = {3'd0, main_addr[14:0]};
        end
    end

endmodule

/* hw/bubl_misc_ctrl.sv */
`timescale 1ns/1ps

module bubl_misc_ctrl (
    input  logic                clk24,
    input  logic                rst,
    input  logic                misc_cs,
    input  bubl_pkg::cpu_data_t main_dout,
    output bubl_pkg::bank_t     bank,
    output logic                sub_rst_n,
    output logic                black_n,
    output logic                flip
);
    import bubl_pkg::*;

    // Misc register at FB40, written as a whole byte
    //   bits 2:0  ROM bank, top bit inverted
    //   bit 4     sub CPU out of reset
    //   bit 6     screen enabled
    //   bit 7     flip
    always_ff @(posedge clk24 or posedge rst) begin
        if (rst) begin
            bank      <= '0;
            sub_rst_n <= 1'b0;    // Sub CPU waits for the main
            black_n   <= 1'b0;
            flip      <= 1'b0;
        end else if (misc_cs) begin
            bank      <= main_dout[2:0] ^ bank_xor;
            sub_rst_n <= main_dout[ctrl_sub_rst_bit];
            black_n   <= main_dout[ctrl_black_bit];
            flip      <= main_dout[ctrl_flip_bit];
        end
    end

endmodule

/* hw/bubl_sound_comm.sv */
`timescale 1ns/1ps

module bubl_sound_comm (
    input  logic                clk24,
    input  logic                rst,
    input  logic                sound_cs,
    input  bubl_pkg::cpu_addr_t main_addr,
    input  logic                main_wr_n,
    input  logic                main_rd_n,
    input  bubl_pkg::cpu_data_t main_dout,
    input  logic                main_stb,
    output bubl_pkg::cpu_data_t snd_latch,
    output logic                snd_stb,
    output logic                snd_rstn,
    output logic                main_flag
);
    import bubl_pkg::*;

    logic snd_wr;
    logic last_main_stb;

    assign snd_wr = sound_cs && !main_wr_n;

    ////////////////////////////////////////
    // Main to sound

    always_ff @(posedge clk24 or posedge rst) begin
        if (rst) begin
            snd_latch <= '0;
            snd_stb   <= 1'b0;
            snd_rstn  <= 1'b1;    // Sound CPU runs from power up
        end else begin
            snd_stb <= snd_wr && main_addr[1:0] == snd_latch_ofs;
            if (snd_wr && main_addr[1:0] == snd_latch_ofs) begin
                snd_latch <= main_dout;
            end
            if (snd_wr && main_addr[1:0] == snd_reset_ofs) begin
                snd_rstn <= ~main_dout[0];
            end
        end
    end

    ////////////////////////////////////////
    // Sound to main flag

    always_ff @(posedge clk24 or posedge rst) begin
        if (rst) begin
            last_main_stb <= 1'b0;
            main_flag     <= 1'b0;
        end else begin
            last_main_stb <= main_stb;
            if (sound_cs && !main_rd_n) main_flag <= 1'b0;  // Cleared by any read
            // A new strobe wins over a read in the same cycle
            if (main_stb && !last_main_stb) main_flag <= 1'b1;
        end
    end

endmodule

/* work_ram/bubl_work_ram.sv */
`timescale 1ns/1ps

module bubl_work_ram (
    input  logic                 clk24,
    input  bubl_pkg::work_addr_t main_waddr,
    input  bubl_pkg::cpu_data_t  main_wdata,
    input  logic                 main_we,
    input  bubl_pkg::work_addr_t sub_waddr,
    input  bubl_pkg::cpu_data_t  sub_wdata,
    input  logic                 sub_we,
    output bubl_pkg::cpu_data_t  work2main,
    output bubl_pkg::cpu_data_t  work2sub
);
    import bubl_pkg::*;

    cpu_data_t mem [0:(1 << work_aw) - 1];

    // Both ports on clk24, read data one cycle later
    always_ff @(posedge clk24) begin
        if (main_we) mem[main_waddr] <= main_wdata;
        if (sub_we) begin
            mem[sub_waddr] <= sub_wdata;    // Sub wins on the same address
        end
        work2main <= mem[main_waddr];
        work2sub  <= mem[sub_waddr];
    end

endmodule

/* work_ram/bubl_bus_arbiter.sv */
`timescale 1ns/1ps

module bubl_bus_arbiter (
    input  logic                clk24,
    input  logic                rst,
    input  logic                cen6,
    input  logic                work_cs,
    input  logic                vram_cs,
    input  logic                main_wr_n,
    input  bubl_pkg::cpu_addr_t sub_addr,
    input  logic                sub_mreq_n,
    input  logic                sub_wr_n,
    output logic                sub_rom_cs,
    output logic                sub_work_cs,
    output logic                main_we,
    output logic                sub_we,
    output logic                main_busy,
    output logic                sub_busy
);
    import bubl_pkg::*;

    logic main_own;   // Main held the work RAM last cycle
    logic sub_own;    // Sub got in first
    logic h1;         // Video half of the VRAM slot

    // Sub map
    assign sub_rom_cs  = !sub_mreq_n && !sub_addr[15];
    assign sub_work_cs = !sub_mreq_n && sub_addr[15:13] == work_page;

    always_ff @(posedge clk24 or posedge rst) begin
        if (rst) begin
            main_own <= 1'b0;
            sub_own  <= 1'b0;
            h1       <= 1'b0;
        end else begin
            main_own <= work_cs;
            if (!sub_work_cs) sub_own <= 1'b0;
            else if (!work_cs) sub_own <= 1'b1;
            if (cen6) h1 <= ~h1;
        end
    end

    assign main_we = work_cs && main_own && !main_wr_n;
    assign sub_we  = sub_work_cs && !sub_wr_n;

    // Wait requests
    assign main_busy = (sub_own && work_cs) || (vram_cs && h1);
    assign sub_busy  = work_cs && sub_work_cs && !sub_own;

endmodule

/* hw/bubl_read_mux.sv */
`timescale 1ns/1ps

module bubl_read_mux (
    input  logic                clk24,
    input  logic                main_rom_cs,
    input  logic                vram_cs,
    input  logic                pal_cs,
    input  logic                work_cs,
    input  logic                sound_cs,
    input  bubl_pkg::cpu_addr_t main_addr,
    input  bubl_pkg::cpu_data_t main_rom_data,
    input  bubl_pkg::cpu_data_t vram_dout,
    input  bubl_pkg::cpu_data_t pal_dout,
    input  bubl_pkg::cpu_data_t work2main,
    input  bubl_pkg::cpu_data_t main_latch,
    input  logic                main_flag,
    input  logic                snd_flag,
    input  logic                sub_rom_cs,
    input  logic                sub_work_cs,
    input  bubl_pkg::cpu_data_t sub_rom_data,
    input  bubl_pkg::cpu_data_t work2sub,
    output bubl_pkg::cpu_data_t main_din,
    output bubl_pkg::cpu_data_t sub_din
);
    import bubl_pkg::*;

    cpu_data_t snd_rd;

    // Odd address gives the status byte
    assign snd_rd = main_addr[0] ? {6'h3f, main_flag, snd_flag} : main_latch;

    always_ff @(posedge clk24) begin
        if (main_rom_cs)  main_din <= main_rom_data;
        else if (vram_cs) main_din <= vram_dout;
        else if (pal_cs)  main_din <= pal_dout;
        else if (work_cs) main_din <= work2main;
        else if (sound_cs) main_din <= snd_rd;
        else main_din <= unmapped_data;  // Includes the old MCU window

        if (sub_rom_cs)       sub_din <= sub_rom_data;
        else if (sub_work_cs) sub_din <= work2sub;
        else sub_din <= unmapped_data;
    end

endmodule

/* hw/bubl_main.sv */
`timescale 1ns/1ps

module bubl_main (
    input  logic                    clk24,
    input  logic                    rst,
    input  logic                    cen6,
    // Main CPU bus
    input  bubl_pkg::cpu_addr_t     main_addr,
    input  logic                    main_mreq_n,
    input  logic                    main_rd_n,
    input  logic                    main_wr_n,
    input  bubl_pkg::cpu_data_t     main_dout,
    output bubl_pkg::cpu_data_t     main_din,
    // Sub CPU bus
    input  bubl_pkg::cpu_addr_t     sub_addr,
    input  logic                    sub_mreq_n,
    input  logic                    sub_wr_n,
    input  bubl_pkg::cpu_data_t     sub_dout,
    output bubl_pkg::cpu_data_t     sub_din,
    // ROMs
    output bubl_pkg::rom_addr_t     main_rom_addr,
    output logic                    main_rom_cs,
    input  bubl_pkg::cpu_data_t     main_rom_data,
    output bubl_pkg::sub_rom_addr_t sub_rom_addr,
    output logic                    sub_rom_cs,
    input  bubl_pkg::cpu_data_t     sub_rom_data,
    // Video
    output logic                    vram_cs,
    input  bubl_pkg::cpu_data_t     vram_dout,
    output logic                    pal_cs,
    input  bubl_pkg::cpu_data_t     pal_dout,
    output logic                    black_n,
    output logic                    flip,
    // CPU control
    output logic                    sub_rst_n,
    output logic                    nmi_stb,
    output logic                    main_busy,
    output logic                    sub_busy,
    // Sound CPU
    input  bubl_pkg::cpu_data_t     main_latch,
    output bubl_pkg::cpu_data_t     snd_latch,
    output logic                    snd_stb,
    output logic                    snd_rstn,
    input  logic                    snd_flag,
    input  logic                    main_stb,
    output logic                    main_flag
);
    import bubl_pkg::*;

    logic      work_cs;
    logic      sound_cs;
    logic      misc_cs;
    bank_t     bank;
    logic      sub_work_cs;
    logic      main_we;
    logic      sub_we;
    cpu_data_t work2main;
    cpu_data_t work2sub;

    assign sub_rom_addr = sub_addr[14:0];

    ////////////////////////////////////////
    // Main CPU side

    bubl_main_decoder u_decoder (
        .main_addr     (main_addr),
        .main_mreq_n   (main_mreq_n),
        .main_wr_n     (main_wr_n),
        .bank          (bank),
        .main_rom_cs   (main_rom_cs),
        .vram_cs       (vram_cs),
        .pal_cs        (pal_cs),
        .work_cs       (work_cs),
        .sound_cs      (sound_cs),
        .misc_cs       (misc_cs),
        .nmi_stb       (nmi_stb),
        .main_rom_addr (main_rom_addr)
    );

    bubl_misc_ctrl u_misc (
        .clk24     (clk24),
        .rst       (rst),
        .misc_cs   (misc_cs),
        .main_dout (main_dout),
        .bank      (bank),
        .sub_rst_n (sub_rst_n),
        .black_n   (black_n),
        .flip      (flip)
    );

    bubl_sound_comm u_sound (
        .clk24     (clk24),
        .rst       (rst),
        .sound_cs  (sound_cs),
        .main_addr (main_addr),
        .main_wr_n (main_wr_n),
        .main_rd_n (main_rd_n),
        .main_dout (main_dout),
        .main_stb  (main_stb),
        .snd_latch (snd_latch),
        .snd_stb   (snd_stb),
        .snd_rstn  (snd_rstn),
        .main_flag (main_flag)
    );

    ////////////////////////////////////////
    // Shared work RAM

    bubl_bus_arbiter u_arbiter (
        .clk24       (clk24),
        .rst         (rst),
        .cen6        (cen6),
        .work_cs     (work_cs),
        .vram_cs     (vram_cs),
        .main_wr_n   (main_wr_n),
        .sub_addr    (sub_addr),
        .sub_mreq_n  (sub_mreq_n),
        .sub_wr_n    (sub_wr_n),
        .sub_rom_cs  (sub_rom_cs),
        .sub_work_cs (sub_work_cs),
        .main_we     (main_we),
        .sub_we      (sub_we),
        .main_busy   (main_busy),
        .sub_busy    (sub_busy)
    );

    bubl_work_ram u_work (
        .clk24      (clk24),
        .main_waddr (main_addr[work_aw-1:0]),
        .main_wdata (main_dout),
        .main_we    (main_we),
        .sub_waddr  (sub_addr[work_aw-1:0]),   // Same offsets as the main window
        .sub_wdata  (sub_dout),
        .sub_we     (sub_we),
        .work2main  (work2main),
        .work2sub   (work2sub)
    );

    ////////////////////////////////////////
    // Read data

    bubl_read_mux u_rdmux (
        .clk24         (clk24),
        .main_rom_cs   (main_rom_cs),
        .vram_cs       (vram_cs),
        .pal_cs        (pal_cs),
        .work_cs       (work_cs),
        .sound_cs      (sound_cs),
        .main_addr     (main_addr),
        .main_rom_data (main_rom_data),
        .vram_dout     (vram_dout),
        .pal_dout      (pal_dout),
        .work2main     (work2main),
        .main_latch    (main_latch),
        .main_flag     (main_flag),
        .snd_flag      (snd_flag),
        .sub_rom_cs    (sub_rom_cs),
        .sub_work_cs   (sub_work_cs),
        .sub_rom_data  (sub_rom_data),
        .work2sub      (work2sub),
        .main_din      (main_din),
        .sub_din       (sub_din)
    );

endmodule

/* testbench/bubl_main_tb.sv */
`timescale 1ns/1ps

module bubl_main_tb;
    import bubl_pkg::*;

    localparam int num_phases   = 6;
    localparam int phase_cycles = 2000;

    logic          clk24 = 1'b0;
    logic          rst = 1'b1;
    logic          cen6 = 1'b0;
    logic [1:0]    cen_cnt = 2'd0;
    cpu_addr_t     main_addr = '0;
    logic          main_mreq_n = 1'b1;
    logic          main_rd_n = 1'b1;
    logic          main_wr_n = 1'b1;
    cpu_data_t     main_dout = '0;
    cpu_data_t     main_din;
    cpu_addr_t     sub_addr = '0;
    logic          sub_mreq_n = 1'b1;
    logic          sub_wr_n = 1'b1;
    cpu_data_t     sub_dout = '0;
    cpu_data_t     sub_din;
    rom_addr_t     main_rom_addr;
    logic          main_rom_cs;
    cpu_data_t     main_rom_data;
    sub_rom_addr_t sub_rom_addr;
    logic          sub_rom_cs;
    cpu_data_t     sub_rom_data;
    logic          vram_cs;
    cpu_data_t     vram_dout;
    logic          pal_cs;
    cpu_data_t     pal_dout;
    logic          black_n;
    logic          flip;
    logic          sub_rst_n;
    logic          nmi_stb;
    logic          main_busy;
    logic          sub_busy;
    cpu_data_t     main_latch = '0;
    cpu_data_t     snd_latch;
    logic          snd_stb;
    logic          snd_rstn;
    logic          snd_flag = 1'b0;
    logic          main_stb = 1'b0;
    logic          main_flag;

    // Reference state from the reset values
    cpu_data_t ref_mem [0:(1 << work_aw) - 1];
    bank_t     ref_bank = '0;
    logic      ref_sub_rst_n = 1'b0;
    logic      ref_black_n = 1'b0;
    logic      ref_flip = 1'b0;
    cpu_data_t ref_latch = '0;
    logic      ref_snd_rstn = 1'b1;
    logic      ref_flag = 1'b0;

    // Sample requests for the compare process
    logic      smp_main = 1'b0;
    logic      smp_sub = 1'b0;
    logic      smp_state = 1'b0;
    logic      smp_busy = 1'b0;
    logic      smp_rd = 1'b0;
    cpu_data_t exp_din = '0;
    rom_addr_t exp_rom_addr = '0;
    logic      exp_rom_cs = 1'b0;
    logic      exp_sub_rom_cs = 1'b0;
    logic      exp_vram_cs = 1'b0;
    logic      exp_pal_cs = 1'b0;
    logic      exp_nmi = 1'b0;
    logic      exp_snd_stb = 1'b0;
    logic      exp_main_busy = 1'b0;
    logic      exp_sub_busy = 1'b0;
    int        checks = 0;
    int        errors = 0;

    bubl_main UUT (.*);

    always #4 clk24 = ~clk24;

    always @(posedge clk24) begin
        #1;
        cen_cnt = cen_cnt + 2'd1;
        cen6    = cen_cnt == 2'd0;  // One pulse every fourth cycle
    end

    ////////////////////////////////////////
    // Memory models and reference

    // Fill pattern over the whole address and salted per source
    function automatic cpu_data_t src_byte(input logic [1:0] kind, input rom_addr_t addr);
        cpu_data_t salt;
        case (kind)
            2'd0:    salt = 8'h00;
            2'd1:    salt = 8'h5a;
            2'd2:    salt = 8'hc3;
            default: salt = 8'h96;
        endcase
        return addr[7:0] ^ {addr[14:8], addr[15]} ^ {6'd0, addr[17:16]} ^ salt;
    endfunction

    assign main_rom_data = src_byte(2'd0, main_rom_addr);
    assign vram_dout     = src_byte(2'd1, {2'b00, main_addr});
    assign pal_dout      = src_byte(2'd2, {2'b00, main_addr});
    assign sub_rom_data  = src_byte(2'd3, {3'b000, sub_rom_addr});

    function automatic rom_addr_t ref_rom_addr(input cpu_addr_t addr);
        int page;
        if (addr < 16'h8000) return {2'b00, addr};
        page = int'(ref_bank) + int'(bank_offset);    // 16 KB pages
        return rom_addr_t'(page * 16384 + int'(addr[13:0]));
    endfunction

    function automatic cpu_data_t ref_main_read(input cpu_addr_t addr);
        if (addr < 16'hc000) return src_byte(2'd0, ref_rom_addr(addr));
        if (addr < 16'he000) return src_byte(2'd1, {2'b00, addr});
        if (addr < 16'hf800) return ref_mem[addr[12:0]];
        if (addr < 16'hfa00) return src_byte(2'd2, {2'b00, addr});
        if (addr < 16'hfa80) return addr[0] ? {6'h3f, ref_flag, snd_flag} : main_latch;
        return unmapped_data;
    endfunction

    function automatic cpu_data_t ref_sub_read(input cpu_addr_t addr);
        if (addr < 16'h8000) return src_byte(2'd3, {3'b000, addr[14:0]});
        if (addr >= 16'he000) return ref_mem[addr[12:0]];
        return unmapped_data;
    endfunction

    task automatic ref_main_write(input cpu_addr_t addr, input cpu_data_t data);
        if (addr >= 16'he000 && addr < 16'hf800) ref_mem[addr[12:0]] = data;
        if (addr >= 16'hfb40 && addr < 16'hfb80) begin   // Misc register
            ref_bank      = data[2:0] ^ bank_xor;
            ref_sub_rst_n = data[4];
            ref_black_n   = data[6];
            ref_flip      = data[7];
        end
        if (addr >= 16'hfa00 && addr < 16'hfa80) begin
            if (addr[1:0] == 2'd0) ref_latch = data;
            if (addr[1:0] == 2'd3) ref_snd_rstn = !data[0];
        end
    endtask

    ////////////////////////////////////////
    // Compare

    task automatic check_data(input string name, input cpu_data_t got, input cpu_data_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("mismatch at %0d ns: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rom_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("mismatch at %0d ns: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("mismatch at %0d ns: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // Samples mid cycle away from the edges
    always @(negedge clk24) begin
        if (smp_main) begin
            check_bit("main_rom_cs", main_rom_cs, exp_rom_cs);
            check_bit("vram_cs", vram_cs, exp_vram_cs);
            check_bit("pal_cs", pal_cs, exp_pal_cs);
            check_bit("nmi_stb", nmi_stb, exp_nmi);
            if (exp_rom_cs) check_rom_addr("main_rom_addr", main_rom_addr, exp_rom_addr);
            if (smp_rd) check_data("main_din", main_din, exp_din);
        end
        if (smp_sub) begin
            check_bit("sub_rom_cs", sub_rom_cs, exp_sub_rom_cs);
            if (smp_rd) check_data("sub_din", sub_din, exp_din);
        end
        if (smp_state) begin
            check_bit("sub_rst_n", sub_rst_n, ref_sub_rst_n);
            check_bit("black_n", black_n, ref_black_n);
            check_bit("flip", flip, ref_flip);
            check_data("snd_latch", snd_latch, ref_latch);
            check_bit("snd_stb", snd_stb, exp_snd_stb);
            check_bit("snd_rstn", snd_rstn, ref_snd_rstn);
            check_bit("main_flag", main_flag, ref_flag);
        end
        if (smp_busy) begin
            check_bit("main_busy", main_busy, exp_main_busy);
            check_bit("sub_busy", sub_busy, exp_sub_busy);
        end
    end

    ////////////////////////////////////////
    // Bus tasks

    task automatic next_cycle();
        @(posedge clk24);
        #1;
    endtask

    task automatic main_drive(input cpu_addr_t addr, input logic wr, input cpu_data_t data);
        main_addr   = addr;
        main_dout   = data;
        main_mreq_n = 1'b0;
        main_rd_n   = wr;
        main_wr_n   = !wr;
    endtask

    task automatic main_idle();
        main_mreq_n = 1'b1;
        main_rd_n   = 1'b1;
        main_wr_n   = 1'b1;
    endtask

    task automatic sub_drive(input cpu_addr_t addr, input logic wr, input cpu_data_t data);
        sub_addr   = addr;
        sub_dout   = data;
        sub_mreq_n = 1'b0;
        sub_wr_n   = !wr;
    endtask

    task automatic sub_idle();
        sub_mreq_n = 1'b1;
        sub_wr_n   = 1'b1;
    endtask

    task automatic main_access(input cpu_addr_t addr, input logic wr, input cpu_data_t data);
        main_drive(addr, wr, data);
        repeat (3) next_cycle();
        if (wr) begin
            ref_main_write(addr, data);
        end else if (addr >= 16'hfa00 && addr < 16'hfa80) begin
            ref_flag = 1'b0;    // Any sound read clears the flag
        end
        exp_din      = ref_main_read(addr);
        exp_rom_addr = ref_rom_addr(addr);
        exp_rom_cs   = addr < 16'hc000;
        exp_vram_cs  = addr >= 16'hc000 && addr < 16'he000;
        exp_pal_cs   = addr >= 16'hf800 && addr < 16'hfa00;
        exp_nmi      = wr && addr >= 16'hfb00 && addr < 16'hfb40;
        smp_rd       = !wr;
        smp_main     = 1'b1;
        next_cycle();
        smp_main = 1'b0;
        main_idle();
    endtask

    task automatic sub_access(input cpu_addr_t addr, input logic wr, input cpu_data_t data);
        sub_drive(addr, wr, data);
        repeat (3) next_cycle();
        if (wr && addr >= 16'he000) ref_mem[addr[12:0]] = data;
        exp_din        = ref_sub_read(addr);
        exp_sub_rom_cs = addr < 16'h8000;
        smp_rd         = !wr;
        smp_sub        = 1'b1;
        next_cycle();
        smp_sub = 1'b0;
        sub_idle();
    endtask

    task automatic state_check(input logic stb);
        exp_snd_stb = stb;
        smp_state   = 1'b1;
        next_cycle();
        smp_state = 1'b0;
    endtask

    task automatic busy_check(input logic main_exp, input logic sub_exp);
        exp_main_busy = main_exp;
        exp_sub_busy  = sub_exp;
        smp_busy      = 1'b1;
        next_cycle();
        smp_busy = 1'b0;
    endtask

    function automatic cpu_data_t rand_byte();
        return cpu_data_t'($urandom);
    endfunction

    function automatic cpu_addr_t rand_ofs(input int span);
        return cpu_addr_t'($urandom % span);
    endfunction

    ////////////////////////////////////////
    // Test sequence

    initial begin
        int        seed_val;
        cpu_addr_t addr;
        cpu_data_t data;
        seed_val = $urandom(26);
        repeat (10) @(posedge clk24);
        #1;
        rst = 1'b0;
        next_cycle();

        // Reset values and unmapped reads
        state_check(1'b0);
        main_access(16'h8000, 1'b0, 8'h00);    // Bank 0 after reset
        main_access(16'hfa80, 1'b0, 8'h00);
        main_access(16'hfb10, 1'b0, 8'h00);
        main_access(16'hfb50, 1'b0, 8'h00);
        main_access(16'hfc00, 1'b0, 8'h00);    // MCU shared RAM window
        main_access(16'hffff, 1'b0, 8'h00);
        sub_access(16'h9000, 1'b0, 8'h00);

        // Misc register and banked ROM
        for (int i = 0; i < 6; i++) begin
            main_access(16'hfb40 + rand_ofs(32'h40), 1'b1, rand_byte());
            state_check(1'b0);
            main_access(16'h8000 + rand_ofs(32'h4000), 1'b0, 8'h00);
        end

        // Work RAM through both ports
        for (int i = 0; i < 16; i++) begin
            addr = 16'he000 + rand_ofs(32'h1800);
            main_access(addr, 1'b1, rand_byte());
            main_access(addr, 1'b0, 8'h00);
            sub_access(addr, 1'b0, 8'h00);
        end
        for (int i = 0; i < 8; i++) begin
            addr = 16'he000 + rand_ofs(32'h1800);
            sub_access(addr, 1'b1, rand_byte());
            main_access(addr, 1'b0, 8'h00);
        end
        addr = 16'hf800 + rand_ofs(32'h800);   // Sub only above F7FF
        sub_access(addr, 1'b1, rand_byte());
        sub_access(addr, 1'b0, 8'h00);

        // Sound latch, reset and flag
        main_latch = rand_byte();
        snd_flag   = ($urandom % 2) != 0;
        data       = rand_byte();
        main_access(16'hfa00, 1'b1, data);
        state_check(1'b1);   // Strobe in the cycle after the write
        state_check(1'b0);
        main_access(16'hfa03, 1'b1, 8'h01);
        state_check(1'b0);
        main_access(16'hfa04, 1'b1, rand_byte());
        state_check(1'b1);
        main_access(16'hfa07, 1'b1, 8'h00);
        state_check(1'b0);
        main_stb = 1'b1;
        next_cycle();
        main_stb = 1'b0;
        ref_flag = 1'b1;
        state_check(1'b0);
        main_access(16'hfa01, 1'b0, 8'h00);    // Status read clears the flag
        state_check(1'b0);
        main_access(16'hfa02, 1'b0, 8'h00);

        // Video, ROM and NMI
        for (int i = 0; i < 8; i++) begin
            main_access(16'hc000 + rand_ofs(32'h2000), 1'b0, 8'h00);
            main_access(16'hf800 + rand_ofs(32'h200), 1'b0, 8'h00);
            main_access(rand_ofs(32'h8000), 1'b0, 8'h00);
            sub_access(rand_ofs(32'h8000), 1'b0, 8'h00);
            main_access(16'hfb00 + rand_ofs(32'h40), 1'b1, rand_byte());
        end

        // Arbitration, main first
        main_drive(16'he100, 1'b0, 8'h00);
        next_cycle();
        sub_drive(16'he200, 1'b0, 8'h00);
        busy_check(1'b0, 1'b1);
        busy_check(1'b0, 1'b1);
        main_idle();
        sub_idle();
        next_cycle();
        // Sub first
        sub_drive(16'he300, 1'b0, 8'h00);
        next_cycle();
        main_drive(16'he400, 1'b0, 8'h00);
        busy_check(1'b1, 1'b0);
        busy_check(1'b1, 1'b0);
        main_idle();
        sub_idle();
        next_cycle();
        // One CPU at a time
        main_drive(16'he500, 1'b0, 8'h00);
        busy_check(1'b0, 1'b0);
        busy_check(1'b0, 1'b0);
        main_idle();
        sub_drive(16'hfe00, 1'b0, 8'h00);
        busy_check(1'b0, 1'b0);
        busy_check(1'b0, 1'b0);
        sub_idle();
        next_cycle();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (num_phases * phase_cycles) @(posedge clk24);
        $display("Timeout: run did not finish within %0d cycles, errors so far: %0d",
                 num_phases * phase_cycles, errors);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* tb.f */
common/bubl_pkg.sv
hw/bubl_main_decoder.sv
hw/bubl_misc_ctrl.sv
hw/bubl_sound_comm.sv
work_ram/bubl_work_ram.sv
work_ram/bubl_bus_arbiter.sv
hw/bubl_read_mux.sv
hw/bubl_main.sv
testbench/bubl_main_tb.sv

/* Makefile */
# Verilator simulation of the bus glue testbench

VERILATOR ?= verilator
TOP       ?= bubl_main_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@if grep -qx "All tests passed" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
